/* all.f */
+incdir+include
design/dcache_pkg.sv
design/data_array.sv
design/meta_array.sv
design/plru_array.sv
design/hit_detection.sv
design/plru_update.sv
design/dcache_ctrl.sv
design/dcache.sv
testbench/line_memory.sv
testbench/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the data cache testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing -f all.f --top-module dcache_tb -o dcache_sim \
    && ./obj_dir/dcache_sim | tee /dev/stderr | grep -F "Done: no errors" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* testbench/dcache_tb.sv */
`timescale 1ns/100ps

module dcache_tb
import dcache_pkg::*;
();

    typedef struct packed {
        addr_t      addr;
        byte_mask_t rmask;
        byte_mask_t wmask;
        word_t      wdata;
        int         test;
    } entry_t;

    logic       clk = 1'b0;
    logic       rst;
    addr_t      ufp_addr;
    byte_mask_t ufp_rmask;
    byte_mask_t ufp_wmask;
    word_t      ufp_wdata;
    word_t      ufp_rdata;
    logic       ufp_resp;
    addr_t      dfp_addr;
    logic       dfp_read;
    logic       dfp_write;
    line_t      dfp_wdata;
    logic       dfp_ready;
    addr_t      dfp_raddr;
    line_t      dfp_rdata;
    logic       dfp_rvalid;

    int         read_count;
    int         write_count;
    addr_t      last_read_addr;
    addr_t      last_write_addr;
    line_t      last_write_data;

    entry_t     table_q [$];
    int         test_checks [7];
    int         test_errors [7];
    string      test_names [7] = '{"", "cold read miss", "read hits", "write hit",
                                   "plru victim", "dirty eviction", "random traffic"};
    int         cycles = 0;
    int         cycle_limit = 0;

    // Golden bytes of the 64-line window and per-set ways and tree bits
    logic [7:0] golden [2048];
    tag_t       way_tag [16][4];
    logic       way_valid [16][4];
    logic       way_dirty [16][4];
    plru_t      tree_bits [16];

    always #2 clk = ~clk;

    dcache dut (.*);

    line_memory mem (
        .clk (clk), .rst (rst), .addr (dfp_addr), .read (dfp_read), .write (dfp_write),
        .wdata (dfp_wdata), .ready (dfp_ready), .raddr (dfp_raddr), .rdata (dfp_rdata),
        .rvalid (dfp_rvalid), .read_count (read_count), .write_count (write_count),
        .last_read_addr (last_read_addr), .last_write_addr (last_write_addr),
        .last_write_data (last_write_data)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // ========================================================================
    // Golden model
    // ========================================================================

    function automatic addr_t make_addr(input int tag, input int set, input int word);
        return addr_t'((tag << 9) | (set << 5) | (word << 2));
    endfunction

    function automatic int golden_index(input addr_t a);
        return int'({a[11:9], a[7:5], a[4:0]});
    endfunction

    function automatic word_t golden_word(input addr_t a);
        word_t w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = golden[golden_index({a[31:2], 2'b00}) + i];
        end
        return w;
    endfunction

    function automatic line_t golden_line(input addr_t a);
        line_t l;
        for (int i = 0; i < 32; i++) begin
            l[8*i +: 8] = golden[golden_index({a[31:5], 5'b00000}) + i];
        end
        return l;
    endfunction

    // Zero points left; bit 0 picks the pair
    function automatic way_t pick_victim(input plru_t b);
        return {b[0], b[0] ? b[2] : b[1]};
    endfunction

    function automatic plru_t touch_way(input plru_t b, input way_t way);
        b[0] = ~way[1];
        if (way[1]) begin
            b[2] = ~way[0];
        end else begin
            b[1] = ~way[0];
        end
        return b;
    endfunction

    task automatic predict(input entry_t e, output logic fill, output logic wb,
                           output addr_t wb_addr, output line_t wb_line);
        set_t s;
        tag_t tg;
        logic hit;
        way_t way;
        s = e.addr[8:5];
        tg = e.addr[31:9];
        hit = 1'b0;
        way = '0;
        fill = 1'b0;
        wb = 1'b0;
        wb_addr = '0;
        wb_line = '0;
        for (int w = 0; w < 4; w++) begin
            if (way_valid[s][w] && way_tag[s][w] == tg) begin
                hit = 1'b1;
                way = 2'(w);
            end
        end
        if (!hit) begin
            way = pick_victim(tree_bits[s]);
            fill = 1'b1;
            if (way_valid[s][way] && way_dirty[s][way]) begin
                wb = 1'b1;
                wb_addr = {way_tag[s][way], s, 5'b00000};
                wb_line = golden_line(wb_addr);
            end
            way_tag[s][way] = tg;
            way_valid[s][way] = 1'b1;
            way_dirty[s][way] = 1'b0;
        end
        if (e.wmask != '0) begin
            way_dirty[s][way] = 1'b1;
        end
        tree_bits[s] = touch_way(tree_bits[s], way);
    endtask

    task automatic apply_write(input entry_t e);
        int base;
        base = golden_index({e.addr[31:2], 2'b00});
        for (int b = 0; b < 4; b++) begin
            if (e.wmask[b]) begin
                golden[base + b] = e.wdata[8*b +: 8];
            end
        end
    endtask

    // ========================================================================
    // Stimulus table
    // ========================================================================

    task automatic add_read(input int test, input int tag, input int set, input int word);
        table_q.push_back('{make_addr(tag, set, word), 4'hf, 4'h0, 32'h0, test});
    endtask

    task automatic add_write(input int test, input int tag, input int set, input int word,
                             input byte_mask_t mask, input word_t data);
        table_q.push_back('{make_addr(tag, set, word), 4'h0, mask, data, test});
    endtask

    task automatic build_table();
        int tags [4] = '{2, 0, 3, 1};
        add_read(1, 0, 0, 0);
        add_read(1, 0, 1, 3);
        add_read(1, 1, 2, 7);
        add_read(2, 0, 0, 1);
        add_read(2, 0, 0, 2);
        add_read(2, 0, 0, 5);
        add_read(2, 1, 2, 0);
        add_write(3, 0, 0, 1, 4'b0110, 32'hcafe_f00d);
        add_read(3, 0, 0, 1);
        add_write(3, 0, 1, 3, 4'b1111, 32'h1234_5678);
        add_read(3, 0, 1, 3);
        // Fill set 3, touch in order, then a fifth tag evicts the oldest
        for (int i = 0; i < 4; i++) begin
            add_read(4, i, 3, 0);
        end
        for (int i = 0; i < 4; i++) begin
            add_read(4, tags[i], 3, 1);
        end
        add_read(4, 4, 3, 2);
        add_read(4, 0, 3, 3);
        add_read(4, 1, 3, 3);
        add_read(4, 3, 3, 3);
        add_read(4, 2, 3, 3);
        add_write(5, 0, 4, 2, 4'b1111, 32'hdead_beef);
        add_write(5, 0, 4, 5, 4'b1001, 32'h8899_aabb);
        add_read(5, 1, 4, 0);
        add_read(5, 2, 4, 0);
        add_read(5, 3, 4, 0);
        add_read(5, 4, 4, 0);
        add_read(5, 0, 4, 2);
        add_read(5, 0, 4, 5);
        for (int i = 0; i < 40; i++) begin
            if ($urandom % 2 == 0) begin
                add_read(6, $urandom % 8, 5 + $urandom % 3, $urandom % 8);
            end else begin
                add_write(6, $urandom % 8, 5 + $urandom % 3, $urandom % 8,
                          byte_mask_t'($urandom % 15 + 1), $urandom);
            end
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        entry_t e;
        logic   exp_fill;
        logic   exp_wb;
        addr_t  wb_addr;
        line_t  wb_line;
        word_t  exp_word;
        word_t  pattern;
        int     reads_before;
        int     writes_before;
        int     t;
        int     total_checks;
        int     total_errors;

        void'($urandom(32'hfcdc));
        rst = 1'b1;
        ufp_addr = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        for (int l = 0; l < 64; l++) begin
            for (int w = 0; w < 8; w++) begin
                pattern = {7'h5a, l[5:0], w[2:0], 7'h2c, l[5:0], w[2:0]};
                for (int b = 0; b < 4; b++) begin
                    golden[l*32 + w*4 + b] = pattern[8*b +: 8];
                end
            end
        end
        for (int s = 0; s < 16; s++) begin
            tree_bits[s] = '0;
            for (int w = 0; w < 4; w++) begin
                way_tag[s][w] = '0;
                way_valid[s][w] = 1'b0;
                way_dirty[s][w] = 1'b0;
            end
        end
        for (int i = 0; i < 7; i++) begin
            test_checks[i] = 0;
            test_errors[i] = 0;
        end
        build_table();
        cycle_limit = table_q.size() * 40;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < table_q.size(); i++) begin
            e = table_q[i];
            t = e.test;
            predict(e, exp_fill, exp_wb, wb_addr, wb_line);
            exp_word = golden_word(e.addr);
            reads_before = read_count;
            writes_before = write_count;
            ufp_addr = e.addr;
            ufp_rmask = e.rmask;
            ufp_wmask = e.wmask;
            ufp_wdata = e.wdata;
            @(negedge clk);
            while (!ufp_resp) begin
                @(negedge clk);
            end
            // Idle unless the next entry is driven in this same cycle
            ufp_rmask = '0;
            ufp_wmask = '0;

            if (e.rmask != '0) begin
                test_checks[t]++;
                if (ufp_rdata !== exp_word) begin
                    $display("MISMATCH at %0t: test %0d read of %h gave %h, expected %h",
                             $time, t, e.addr, ufp_rdata, exp_word);
                    test_errors[t]++;
                end
            end
            test_checks[t]++;
            if (read_count - reads_before != (exp_fill ? 1 : 0)
                    || (exp_fill && last_read_addr !== {e.addr[31:5], 5'b00000})) begin
                $display("MISMATCH at %0t: test %0d access to %h made %0d line reads at %h",
                         $time, t, e.addr, read_count - reads_before, last_read_addr);
                test_errors[t]++;
            end
            test_checks[t]++;
            if (write_count - writes_before != (exp_wb ? 1 : 0)
                    || (exp_wb && last_write_addr !== wb_addr)
                    || (exp_wb && last_write_data !== wb_line)) begin
                $display("MISMATCH at %0t: test %0d access to %h made %0d write-backs at %h",
                         $time, t, e.addr, write_count - writes_before, last_write_addr);
                test_errors[t]++;
            end
            apply_write(e);

            if (i == table_q.size() - 1 || table_q[i+1].test != t) begin
                $display("Test %0d, %s: %0d checks, %0d errors",
                         t, test_names[t], test_checks[t], test_errors[t]);
            end
        end

        total_checks = 0;
        total_errors = 0;
        for (int i = 0; i < 7; i++) begin
            total_checks += test_checks[i];
            total_errors += test_errors[i];
        end
        $display("Finished %0d requests: %0d checks, %0d errors",
                 table_q.size(), total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* testbench/line_memory.sv */
`timescale 1ns/100ps

module line_memory
import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  addr_t   addr,
    input  logic    read,
    input  logic    write,
    input  line_t   wdata,
    output logic    ready,
    output addr_t   raddr,
    output line_t   rdata,
    output logic    rvalid,
    output int      read_count,
    output int      write_count,
    output addr_t   last_read_addr,
    output addr_t   last_write_addr,
    output line_t   last_write_data
);

    line_t  lines [64];
    logic   pending;
    int     countdown;
    addr_t  pending_addr;

    // The 64-line window is indexed by tag bits 11:9 and set bits 7:5
    function automatic logic [5:0] line_index(input addr_t a);
        return {a[11:9], a[7:5]};
    endfunction

    initial begin
        for (int l = 0; l < 64; l++) begin
            for (int w = 0; w < 8; w++) begin
                lines[l][32*w +: 32] = {7'h5a, l[5:0], w[2:0], 7'h2c, l[5:0], w[2:0]};
            end
        end
        ready = 1'b0;
        rvalid = 1'b0;
        raddr = '0;
        rdata = '0;
        pending = 1'b0;
        countdown = 0;
        pending_addr = '0;
        read_count = 0;
        write_count = 0;
        last_read_addr = '0;
        last_write_addr = '0;
        last_write_data = '0;

        // ready set here is the handshake seen at the next rising edge
        forever begin
            @(negedge clk);
            if (rst) begin
                ready = 1'b0;
                rvalid = 1'b0;
                pending = 1'b0;
            end else begin
                rvalid = 1'b0;
                if (pending) begin
                    countdown--;
                    if (countdown == 0) begin
                        pending = 1'b0;
                        rvalid = 1'b1;
                        raddr = pending_addr;
                        rdata = lines[line_index(pending_addr)];
                    end
                end
                ready = ($urandom % 4) != 0;
                if (ready && write) begin
                    lines[line_index(addr)] = wdata;
                    write_count++;
                    last_write_addr = addr;
                    last_write_data = wdata;
                end
                if (ready && read) begin
                    pending = 1'b1;
                    countdown = $urandom % 6 + 1;
                    pending_addr = addr;
                    read_count++;
                    last_read_addr = addr;
                end
            end
        end
    end

endmodule

/* design/dcache.sv */
`timescale 1ns/100ps
`include "dcache_macros.svh"

module dcache
import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // CPU side
    input  addr_t       ufp_addr,
    input  byte_mask_t  ufp_rmask,
    input  byte_mask_t  ufp_wmask,
    input  word_t       ufp_wdata,
    output word_t       ufp_rdata,
    output logic        ufp_resp,

    // Memory side
    output addr_t       dfp_addr,
    output logic        dfp_read,
    output logic        dfp_write,
    output line_t       dfp_wdata,
    input  logic        dfp_ready,
    input  addr_t       dfp_raddr,
    input  line_t       dfp_rdata,
    input  logic        dfp_rvalid
);

    localparam int num_ways = `DCACHE_NUM_WAYS;

    offset_t                ufp_offset;
    set_t                   ufp_set;
    tag_t                   ufp_tag;

    byte_mask_t             stage_rmask;
    byte_mask_t             stage_wmask;
    word_t                  stage_wdata;
    offset_t                stage_offset;
    set_t                   stage_set;
    tag_t                   stage_tag;

    logic                   stage_request;
    logic                   stage_is_write;
    addr_t                  stage_line_addr;
    logic [`DCACHE_OFFSET_BITS-3:0] word_sel;

    logic                   ctrl_request;
    logic                   ctrl_stall;
    logic                   stall;
    logic                   refresh;
    logic                   write_hit;
    logic                   allocate;
    logic                   fill_valid;

    set_t                   array_set;
    logic                   way_en [num_ways];
    logic                   way_we [num_ways];
    line_mask_t             data_wmask;
    line_t                  data_din;

    line_t                  data_dout [num_ways];
    logic                   meta_valid [num_ways];
    logic                   meta_dirty [num_ways];
    tag_t                   meta_tag [num_ways];

    logic                   hit;
    way_t                   hit_way;
    way_t                   victim;
    logic                   victim_dirty;
    plru_t                  plru_bits;
    plru_t                  plru_next;

    // ======================================================================
    // Front stage
    // ======================================================================

    assign ufp_offset = ufp_addr[0 +: `DCACHE_OFFSET_BITS];
    assign ufp_set    = ufp_addr[`DCACHE_OFFSET_BITS +: `DCACHE_SET_BITS];
    assign ufp_tag    = ufp_addr[`DCACHE_OFFSET_BITS + `DCACHE_SET_BITS +: `DCACHE_TAG_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_rmask <= '0;
            stage_wmask <= '0;
        end else if (!stall) begin
            stage_rmask <= ufp_rmask;
            stage_wmask <= ufp_wmask;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            stage_wdata  <= ufp_wdata;
            stage_offset <= ufp_offset;
            stage_set    <= ufp_set;
            stage_tag    <= ufp_tag;
        end
    end

    // Arrays were written last cycle, so their outputs are stale for one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            refresh <= 1'b0;
        end else begin
            refresh <= write_hit || allocate;
        end
    end

    assign array_set = (stall || write_hit) ? stage_set : ufp_set;

    always_comb begin
        for (int i = 0; i < num_ways; i++) begin
            way_we[i] = (write_hit && hit_way == way_t'(i))
                     || (allocate && victim == way_t'(i));
            way_en[i] = !stall || refresh || way_we[i];
        end
    end

    // Fill writes the whole line and a write hit only its word's bytes
    always_comb begin
        if (allocate) begin
            data_wmask = '1;
            data_din   = dfp_rdata;
        end else begin
            data_wmask = line_mask_t'(stage_wmask) << {word_sel, 2'b00};
            data_din   = {(`DCACHE_LINE_BITS / 32){stage_wdata}};
        end
    end

    for (genvar i = 0; i < num_ways; i++) begin : g_way
        data_array u_data (
            .clk    (clk),
            .en     (way_en[i]),
            .we     (way_we[i]),
            .addr   (array_set),
            .wmask  (data_wmask),
            .din    (data_din),
            .dout   (data_dout[i])
        );

        meta_array u_meta (
            .clk        (clk),
            .rst        (rst),
            .en         (way_en[i]),
            .we         (way_we[i]),
            .addr       (array_set),
            .din_tag    (stage_tag),
            .din_dirty  (stage_is_write),
            .dout_valid (meta_valid[i]),
            .dout_dirty (meta_dirty[i]),
            .dout_tag   (meta_tag[i])
        );
    end

    plru_array u_plru_array (
        .clk     (clk),
        .rst     (rst),
        .rd_en   (!stall),
        .rd_set  (ufp_set),
        .rd_bits (plru_bits),
        .wr_en   (ufp_resp),
        .wr_set  (stage_set),
        .wr_bits (plru_next)
    );

    // ======================================================================
    // Process stage
    // ======================================================================

    assign stage_request   = (|stage_rmask) || (|stage_wmask);
    assign stage_is_write  = |stage_wmask;
    assign stage_line_addr = {stage_tag, stage_set, {`DCACHE_OFFSET_BITS{1'b0}}};
    assign word_sel        = stage_offset[`DCACHE_OFFSET_BITS-1:2];

    hit_detection u_hit_detection (
        .tag        (stage_tag),
        .way_tags   (meta_tag),
        .way_valid  (meta_valid),
        .hit        (hit),
        .hit_way    (hit_way)
    );

    plru_update u_plru_update (
        .current    (plru_bits),
        .hit_way    (hit_way),
        .victim     (victim),
        .next_bits  (plru_next)
    );

    assign victim_dirty = meta_valid[victim] && meta_dirty[victim];
    assign ctrl_request = stage_request && !refresh;
    // Only accept the fill for the line that was asked for
    assign fill_valid   = dfp_rvalid && (dfp_raddr == stage_line_addr);

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .request      (ctrl_request),
        .is_write     (stage_is_write),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .dfp_ready    (dfp_ready),
        .dfp_rvalid   (fill_valid),
        .stall        (ctrl_stall),
        .write_hit    (write_hit),
        .allocate     (allocate),
        .dfp_read     (dfp_read),
        .dfp_write    (dfp_write)
    );

    assign stall = ctrl_stall || refresh;

    assign dfp_addr  = dfp_write ? {meta_tag[victim], stage_set, {`DCACHE_OFFSET_BITS{1'b0}}}
                                 : stage_line_addr;
    assign dfp_wdata = data_dout[victim];

    assign ufp_rdata = data_dout[hit_way][{word_sel, 5'b00000} +: 32];
    assign ufp_resp  = stage_request && !stall;

endmodule

/* design/dcache_ctrl.sv */
`timescale 1ns/100ps

module dcache_ctrl
import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    request,
    input  logic    is_write,
    input  logic    hit,
    input  logic    victim_dirty,

    input  logic    dfp_ready,
    input  logic    dfp_rvalid,

    output logic    stall,
    output logic    write_hit,
    output logic    allocate,
    output logic    dfp_read,
    output logic    dfp_write
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= COMPARE;
        end else begin
            state <= state_next;
        end
    end

    // ======================================================================
    // Next state
    // ======================================================================

    always_comb begin
        state_next = state;
        case (state)
            COMPARE: begin
                if (request) begin
                    if (hit) begin
                        if (is_write) begin
                            state_next = WRITE_HIT;
                        end
                    end else if (victim_dirty) begin
                        state_next = WRITEBACK;
                    end else begin
                        state_next = FILL_REQ;
                    end
                end
            end
            WRITE_HIT: begin
                state_next = COMPARE;
            end
            // Hold until memory takes the victim line
            WRITEBACK: begin
                if (dfp_ready) begin
                    state_next = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (dfp_ready) begin
                    state_next = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                if (dfp_rvalid) begin
                    state_next = ALLOCATE;
                end
            end
            ALLOCATE: begin
                state_next = COMPARE;
            end
            default: begin
                state_next = COMPARE;
            end
        endcase
    end

    // ======================================================================
    // Outputs
    // ======================================================================

    // The line is written as it arrives and ALLOCATE re-reads the set
    assign allocate  = (state == FILL_WAIT) && dfp_rvalid;
    assign write_hit = (state == WRITE_HIT);
    assign dfp_read  = (state == FILL_REQ);
    assign dfp_write = (state == WRITEBACK);

    always_comb begin
        case (state)
            COMPARE:   stall = request && !(hit && !is_write);
            // Write hit answers while its data goes in
            WRITE_HIT: stall = 1'b0;
            default:   stall = 1'b1;
        endcase
    end

endmodule

/* design/plru_update.sv */
`timescale 1ns/100ps

module plru_update
import dcache_pkg::*;
(
    input  plru_t   current,
    input  way_t    hit_way,
    output way_t    victim,
    output plru_t   next_bits
);

    // ======================================================================
    // Tree layout
    //   bit 0 picks the pair (0 for ways 0/1 and 1 for ways 2/3)
    //   bit 1 picks within ways 0/1 and bit 2 within ways 2/3
    // ======================================================================

    // Follow the bits down the tree
    always_comb begin
        if (!current[0]) begin
            victim = current[1] ? 2'd1 : 2'd0;
        end else begin
            victim = current[2] ? 2'd3 : 2'd2;
        end
    end

    // Point every node on the accessed path away from it
    always_comb begin
        next_bits = current;
        case (hit_way)
            2'd0: begin
                next_bits[0] = 1'b1;
                next_bits[1] = 1'b1;
            end
            2'd1: begin
                next_bits[0] = 1'b1;
                next_bits[1] = 1'b0;
            end
            2'd2: begin
                next_bits[0] = 1'b0;
                next_bits[2] = 1'b1;
            end
            default: begin
                next_bits[0] = 1'b0;
                next_bits[2] = 1'b0;
            end
        endcase
    end

endmodule

/* design/hit_detection.sv */
`timescale 1ns/100ps
`include "dcache_macros.svh"

module hit_detection
import dcache_pkg::*;
(
    input  tag_t    tag,
    input  tag_t    way_tags [`DCACHE_NUM_WAYS],
    input  logic    way_valid [`DCACHE_NUM_WAYS],
    output logic    hit,
    output way_t    hit_way
);

    // At most one valid way holds a given tag
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < `DCACHE_NUM_WAYS; i++) begin
            if (way_valid[i] && way_tags[i] == tag) begin
                hit     = 1'b1;
                hit_way = way_t'(i);
            end
        end
    end

endmodule

/* design/plru_array.sv */
`timescale 1ns/100ps
`include "dcache_macros.svh"

module plru_array
import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    rd_en,
    input  set_t    rd_set,
    output plru_t   rd_bits,
    input  logic    wr_en,
    input  set_t    wr_set,
    input  plru_t   wr_bits
);

    localparam int num_sets = 1 << `DCACHE_SET_BITS;

    plru_t bits [num_sets];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_sets; i++) begin
                bits[i] <= '0;
            end
            rd_bits <= '0;
        end else begin
            if (wr_en) begin
                bits[wr_set] <= wr_bits;
            end
            if (rd_en) begin
                // Forward the update when both ports hit the same set
                if (wr_en && wr_set == rd_set) begin
                    rd_bits <= wr_bits;
                end else begin
                    rd_bits <= bits[rd_set];
                end
            end
        end
    end

endmodule

/* design/meta_array.sv */
`timescale 1ns/100ps
`include "dcache_macros.svh"

module meta_array
import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    en,
    input  logic    we,
    input  set_t    addr,
    input  tag_t    din_tag,
    input  logic    din_dirty,
    output logic    dout_valid,
    output logic    dout_dirty,
    output tag_t    dout_tag
);

    localparam int num_sets = 1 << `DCACHE_SET_BITS;

    logic [num_sets-1:0]    valid;
    logic [num_sets-1:0]    dirty;
    tag_t                   tags [num_sets];

    // Every set starts invalid and clean
    always_ff @(posedge clk) begin
        if (rst) begin
            valid      <= '0;
            dirty      <= '0;
            dout_valid <= 1'b0;
            dout_dirty <= 1'b0;
        end else if (en) begin
            if (we) begin
                valid[addr] <= 1'b1;
                dirty[addr] <= din_dirty;
            end else begin
                dout_valid <= valid[addr];
                dout_dirty <= dirty[addr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                tags[addr] <= din_tag;
            end else begin
                dout_tag <= tags[addr];
            end
        end
    end

endmodule

/* design/data_array.sv */
`timescale 1ns/100ps
`include "dcache_macros.svh"

module data_array
import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        en,
    input  logic        we,
    input  set_t        addr,
    input  line_mask_t  wmask,
    input  line_t       din,
    output line_t       dout
);

    localparam int num_sets  = 1 << `DCACHE_SET_BITS;
    localparam int num_bytes = `DCACHE_LINE_BITS / 8;

    line_t mem [num_sets];

    // A write leaves dout unchanged on this single port
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int i = 0; i < num_bytes; i++) begin
                    if (wmask[i]) begin
                        mem[addr][8*i +: 8] <= din[8*i +: 8];
                    end
                end
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

/* design/dcache_pkg.sv */
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [31:0]                            addr_t;
    typedef logic [31:0]                            word_t;
    typedef logic [3:0]                             byte_mask_t;
    typedef logic [`DCACHE_LINE_BITS-1:0]           line_t;
    typedef logic [`DCACHE_LINE_BITS/8-1:0]         line_mask_t;

    typedef logic [`DCACHE_TAG_BITS-1:0]            tag_t;
    typedef logic [`DCACHE_SET_BITS-1:0]            set_t;
    typedef logic [`DCACHE_OFFSET_BITS-1:0]         offset_t;
    typedef logic [$clog2(`DCACHE_NUM_WAYS)-1:0]    way_t;
    // One bit per internal node of the PLRU tree
    typedef logic [`DCACHE_NUM_WAYS-2:0]            plru_t;

    typedef enum logic [2:0] {
        COMPARE,
        WRITE_HIT,
        WRITEBACK,
        FILL_REQ,
        FILL_WAIT,
        ALLOCATE
    } ctrl_state_t;

endpackage

/* include/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// ===========================================================================
// Data cache geometry
// ===========================================================================

// Associativity
`define DCACHE_NUM_WAYS     4

// 16 sets
`define DCACHE_SET_BITS     4

// 32-byte lines
`define DCACHE_OFFSET_BITS  5

// Tag is what remains of a 32-bit address
`define DCACHE_TAG_BITS     23

`define DCACHE_LINE_BITS    256

`endif
